// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx 'Test passed' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mips_core.f ====
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/reg_file.sv
src/forwarding_unit.sv
src/pipe_decode.sv
src/pipe_execute.sv
src/pipe_retire.sv
src/mips_core.sv
test/wb_checker.sv
test/tb_mips_core.sv

// ==== src/forwarding_unit.sv ====
`timescale 1ns/1ns

module forwarding_unit (
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_ex_rs,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_ex_rt,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_mem_rd,
  input  logic                                i_mem_reg_write,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_wb_rd,
  input  logic                                i_wb_reg_write,
  output mips_pipe_pkg::fwd_sel_e             o_forward_a,
  output mips_pipe_pkg::fwd_sel_e             o_forward_b
);

  logic mem_live;
  logic wb_live;

  // A stage only forwards if it really writes a nonzero register
  assign mem_live = i_mem_reg_write && (i_mem_rd != '0);
  assign wb_live  = i_wb_reg_write && (i_wb_rd != '0);

  // Same priority test for both operands
  // Newest producer first, then the older one, else the register file
  function automatic mips_pipe_pkg::fwd_sel_e pick_src(
    input logic [mips_isa_pkg::reg_addr_w-1:0] src
  );
    if (mem_live && (i_mem_rd == src)) begin
      return mips_pipe_pkg::fwd_mem;
    end else if (wb_live && (i_wb_rd == src)) begin
      return mips_pipe_pkg::fwd_wb;
    end
    return mips_pipe_pkg::fwd_none;
  endfunction

  always_comb begin
    // Operand A from rs
    o_forward_a = pick_src(i_ex_rs);
    // Operand B from rt
    o_forward_b = pick_src(i_ex_rt);
  end

endmodule

// ==== src/mips_core.sv ====
`timescale 1ns/1ns

module mips_core (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_valid,
  input  logic [mips_isa_pkg::data_w-1:0]     i_instr,
  output logic                                o_wb_valid,
  output logic [mips_isa_pkg::reg_addr_w-1:0] o_wb_rd,
  output logic [mips_isa_pkg::data_w-1:0]     o_wb_data
);

  logic [mips_isa_pkg::reg_addr_w-1:0] rs_addr;
  logic [mips_isa_pkg::reg_addr_w-1:0] rt_addr;
  logic [mips_isa_pkg::data_w-1:0]     rs_data;
  logic [mips_isa_pkg::data_w-1:0]     rt_data;
  mips_pipe_pkg::id_ex_t               id_ex;
  mips_pipe_pkg::ex_mem_t              ex_mem;
  mips_pipe_pkg::mem_wb_t              mem_wb;
  mips_pipe_pkg::fwd_sel_e             forward_a;
  mips_pipe_pkg::fwd_sel_e             forward_b;

  // Decode and register read
  pipe_decode u_decode (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr),
    .o_rs_addr(rs_addr), .o_rt_addr(rt_addr),
    .i_rs_data(rs_data), .i_rt_data(rt_data), .o_id_ex(id_ex)
  );

  // Write port is fed from MEM/WB
  reg_file u_reg_file (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rd_addr_a(rs_addr), .i_rd_addr_b(rt_addr),
    .i_wr_en(mem_wb.reg_write), .i_wr_addr(mem_wb.rd), .i_wr_data(mem_wb.result),
    .o_rd_data_a(rs_data), .o_rd_data_b(rt_data)
  );

  // Hazard compare of execute sources against later stages
  forwarding_unit u_forwarding (
    .i_ex_rs(id_ex.rs), .i_ex_rt(id_ex.rt),
    .i_mem_rd(ex_mem.rd), .i_mem_reg_write(ex_mem.reg_write),
    .i_wb_rd(mem_wb.rd), .i_wb_reg_write(mem_wb.reg_write),
    .o_forward_a(forward_a), .o_forward_b(forward_b)
  );

  pipe_execute u_execute (
    .i_clk(i_clk), .i_rst(i_rst), .i_id_ex(id_ex),
    .i_forward_a(forward_a), .i_forward_b(forward_b),
    .i_mem_wb(mem_wb), .o_ex_mem(ex_mem)
  );

  pipe_retire u_retire (
    .i_clk(i_clk), .i_rst(i_rst), .i_ex_mem(ex_mem), .o_mem_wb(mem_wb),
    .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
  );

endmodule

// ==== src/mips_isa_pkg.sv ====
package mips_isa_pkg;

  // Register file geometry
  localparam int reg_addr_w = 5;
  localparam int data_w     = 32;
  localparam int num_regs   = 32;

  // Instruction field widths
  localparam int opcode_w = 6;
  localparam int funct_w  = 6;
  localparam int imm_w    = 16;

  // Low bit of each register field in the instruction word
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;

  // Primary opcodes, anything else decodes as a no-op
  typedef enum logic [opcode_w-1:0] {
    op_rtype = 6'h00,
    op_addi  = 6'h08
  } opcode_e;

  // R-type function codes
  typedef enum logic [funct_w-1:0] {
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_e;

  // Operations the execute stage ALU can perform
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_e;

endpackage

// ==== src/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

  // Operand source select from the forwarding unit
  // Memory stage wins over write-back when both match
  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_mem  = 2'b01,
    fwd_wb   = 2'b10
  } fwd_sel_e;

  // ID/EX register contents
  // Immediate is already sign extended to a full word
  typedef struct packed {
    logic                                valid;
    logic                                reg_write;
    mips_isa_pkg::alu_op_e               alu_op;
    logic                                use_imm;
    logic [mips_isa_pkg::reg_addr_w-1:0] rs;
    logic [mips_isa_pkg::reg_addr_w-1:0] rt;
    logic [mips_isa_pkg::reg_addr_w-1:0] rd;
    logic [mips_isa_pkg::data_w-1:0]     rs_data;
    logic [mips_isa_pkg::data_w-1:0]     rt_data;
    logic [mips_isa_pkg::data_w-1:0]     imm;
  } id_ex_t;

  // EX/MEM register contents
  typedef struct packed {
    logic                                valid;
    logic                                reg_write;
    logic [mips_isa_pkg::reg_addr_w-1:0] rd;
    logic [mips_isa_pkg::data_w-1:0]     result;
  } ex_mem_t;

  // MEM/WB register contents
  // Same layout as EX/MEM since there is no data memory
  typedef struct packed {
    logic                                valid;
    logic                                reg_write;
    logic [mips_isa_pkg::reg_addr_w-1:0] rd;
    logic [mips_isa_pkg::data_w-1:0]     result;
  } mem_wb_t;

endpackage

// ==== src/pipe_decode.sv ====
`timescale 1ns/1ns

module pipe_decode (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_valid,
  input  logic [mips_isa_pkg::data_w-1:0]     i_instr,
  output logic [mips_isa_pkg::reg_addr_w-1:0] o_rs_addr,
  output logic [mips_isa_pkg::reg_addr_w-1:0] o_rt_addr,
  input  logic [mips_isa_pkg::data_w-1:0]     i_rs_data,
  input  logic [mips_isa_pkg::data_w-1:0]     i_rt_data,
  output mips_pipe_pkg::id_ex_t               o_id_ex
);

  logic                                if_valid;
  logic [mips_isa_pkg::data_w-1:0]     if_instr;
  logic [mips_isa_pkg::opcode_w-1:0]   opcode;
  logic [mips_isa_pkg::funct_w-1:0]    funct;
  logic [mips_isa_pkg::imm_w-1:0]      imm16;
  logic [mips_isa_pkg::reg_addr_w-1:0] rd_field;
  logic                                supported;
  mips_pipe_pkg::id_ex_t               id_ex_d;

  // Incoming instruction is captured before decode
  always_ff @(posedge i_clk) begin
    if_instr <= i_instr;
    if_valid <= i_rst ? 1'b0 : i_valid;
  end

  // Field split
  assign opcode    = if_instr[mips_isa_pkg::data_w-1 -: mips_isa_pkg::opcode_w];
  assign funct     = if_instr[mips_isa_pkg::funct_w-1:0];
  assign imm16     = if_instr[mips_isa_pkg::imm_w-1:0];
  assign rd_field  = if_instr[mips_isa_pkg::rd_lsb +: mips_isa_pkg::reg_addr_w];
  assign o_rs_addr = if_instr[mips_isa_pkg::rs_lsb +: mips_isa_pkg::reg_addr_w];
  assign o_rt_addr = if_instr[mips_isa_pkg::rt_lsb +: mips_isa_pkg::reg_addr_w];

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.alu_op  = mips_isa_pkg::alu_add;
    id_ex_d.rs      = o_rs_addr;
    id_ex_d.rt      = o_rt_addr;
    id_ex_d.rd      = rd_field;
    id_ex_d.rs_data = i_rs_data;
    id_ex_d.rt_data = i_rt_data;
    // Sign extend the 16-bit immediate
    id_ex_d.imm = {{(mips_isa_pkg::data_w - mips_isa_pkg::imm_w){imm16[mips_isa_pkg::imm_w-1]}},
                   imm16};
    supported = 1'b1;
    case (opcode)
      mips_isa_pkg::op_rtype: begin
        case (funct)
          mips_isa_pkg::fn_add: id_ex_d.alu_op = mips_isa_pkg::alu_add;
          mips_isa_pkg::fn_sub: id_ex_d.alu_op = mips_isa_pkg::alu_sub;
          mips_isa_pkg::fn_and: id_ex_d.alu_op = mips_isa_pkg::alu_and;
          mips_isa_pkg::fn_or:  id_ex_d.alu_op = mips_isa_pkg::alu_or;
          mips_isa_pkg::fn_slt: id_ex_d.alu_op = mips_isa_pkg::alu_slt;
          default:              supported = 1'b0;
        endcase
      end
      mips_isa_pkg::op_addi: begin
        // addi writes rt and takes B from the immediate
        id_ex_d.use_imm = 1'b1;
        id_ex_d.rd      = o_rt_addr;
      end
      default: supported = 1'b0;
    endcase
    id_ex_d.valid     = if_valid;
    // Unsupported codes still flow but never write back
    id_ex_d.reg_write = if_valid && supported;
  end

  // ID/EX register, only control bits are reset
  always_ff @(posedge i_clk) begin
    o_id_ex <= id_ex_d;
    if (i_rst) begin
      o_id_ex.valid     <= 1'b0;
      o_id_ex.reg_write <= 1'b0;
    end
  end

endmodule

// ==== src/pipe_execute.sv ====
`timescale 1ns/1ns

module pipe_execute (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  mips_pipe_pkg::id_ex_t   i_id_ex,
  input  mips_pipe_pkg::fwd_sel_e i_forward_a,
  input  mips_pipe_pkg::fwd_sel_e i_forward_b,
  input  mips_pipe_pkg::mem_wb_t  i_mem_wb,
  output mips_pipe_pkg::ex_mem_t  o_ex_mem
);

  logic [mips_isa_pkg::data_w-1:0] op_a;
  logic [mips_isa_pkg::data_w-1:0] rt_val;
  logic [mips_isa_pkg::data_w-1:0] op_b;
  logic [mips_isa_pkg::data_w-1:0] alu_y;
  mips_pipe_pkg::ex_mem_t          ex_mem_d;

  // Forwarding mux shared by both operands
  function automatic logic [mips_isa_pkg::data_w-1:0] fwd_pick(
    input mips_pipe_pkg::fwd_sel_e        sel,
    input logic [mips_isa_pkg::data_w-1:0] reg_val,
    input logic [mips_isa_pkg::data_w-1:0] mem_val,
    input logic [mips_isa_pkg::data_w-1:0] wb_val
  );
    case (sel)
      mips_pipe_pkg::fwd_mem: return mem_val;
      mips_pipe_pkg::fwd_wb:  return wb_val;
      default:                return reg_val;
    endcase
  endfunction

  always_comb begin
    // EX/MEM output is the memory stage forwarding source
    op_a   = fwd_pick(i_forward_a, i_id_ex.rs_data, o_ex_mem.result, i_mem_wb.result);
    rt_val = fwd_pick(i_forward_b, i_id_ex.rt_data, o_ex_mem.result, i_mem_wb.result);
    // Immediate overrides B after forwarding
    op_b = i_id_ex.use_imm ? i_id_ex.imm : rt_val;
    alu_y = '0;
    case (i_id_ex.alu_op)
      mips_isa_pkg::alu_add: alu_y = op_a + op_b;
      mips_isa_pkg::alu_sub: alu_y = op_a - op_b;
      mips_isa_pkg::alu_and: alu_y = op_a & op_b;
      mips_isa_pkg::alu_or:  alu_y = op_a | op_b;
      // Signed compare, result is 0 or 1
      mips_isa_pkg::alu_slt: alu_y[0] = $signed(op_a) < $signed(op_b);
      default:               alu_y = op_a + op_b;
    endcase
  end

  always_comb begin
    ex_mem_d.valid     = i_id_ex.valid;
    ex_mem_d.reg_write = i_id_ex.reg_write;
    ex_mem_d.rd        = i_id_ex.rd;
    ex_mem_d.result    = alu_y;
  end

  // EX/MEM register
  always_ff @(posedge i_clk) begin
    o_ex_mem <= ex_mem_d;
    if (i_rst) begin
      o_ex_mem.valid     <= 1'b0;
      o_ex_mem.reg_write <= 1'b0;
    end
  end

endmodule

// ==== src/pipe_retire.sv ====
`timescale 1ns/1ns

module pipe_retire (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  mips_pipe_pkg::ex_mem_t              i_ex_mem,
  output mips_pipe_pkg::mem_wb_t              o_mem_wb,
  output logic                                o_wb_valid,
  output logic [mips_isa_pkg::reg_addr_w-1:0] o_wb_rd,
  output logic [mips_isa_pkg::data_w-1:0]     o_wb_data
);

  mips_pipe_pkg::mem_wb_t mem_wb_d;

  // No data memory, so the memory stage just passes its result on
  always_comb begin
    mem_wb_d.valid     = i_ex_mem.valid;
    mem_wb_d.reg_write = i_ex_mem.reg_write;
    mem_wb_d.rd        = i_ex_mem.rd;
    mem_wb_d.result    = i_ex_mem.result;
  end

  // MEM/WB register
  always_ff @(posedge i_clk) begin
    o_mem_wb <= mem_wb_d;
    if (i_rst) begin
      o_mem_wb.valid     <= 1'b0;
      o_mem_wb.reg_write <= 1'b0;
    end
  end

  // Write-back report
  // Pulses once per retiring instruction that writes a register
  assign o_wb_valid = o_mem_wb.valid & o_mem_wb.reg_write;
  assign o_wb_rd    = o_mem_wb.rd;
  assign o_wb_data  = o_mem_wb.result;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_rd_addr_a,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_rd_addr_b,
  input  logic                                i_wr_en,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_wr_addr,
  input  logic [mips_isa_pkg::data_w-1:0]     i_wr_data,
  output logic [mips_isa_pkg::data_w-1:0]     o_rd_data_a,
  output logic [mips_isa_pkg::data_w-1:0]     o_rd_data_b
);

  logic [mips_isa_pkg::data_w-1:0] regs [mips_isa_pkg::num_regs];
  logic                            wr_live;

  // Writes to r0 are dropped so it stays zero
  assign wr_live = i_wr_en && (i_wr_addr != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < mips_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // Write-first read ports
  // A read of the register being written sees the new value
  always_comb begin
    o_rd_data_a = regs[i_rd_addr_a];
    o_rd_data_b = regs[i_rd_addr_b];
    if (wr_live && (i_rd_addr_a == i_wr_addr)) begin
      o_rd_data_a = i_wr_data;
    end
    if (wr_live && (i_rd_addr_b == i_wr_addr)) begin
      o_rd_data_b = i_wr_data;
    end
  end

endmodule

// ==== test/tb_mips_core.sv ====
`timescale 1ns/1ns

module tb_mips_core;

  localparam int reset_cycles = 8;
  localparam int drain_cycles = 6;
  localparam int num_tests    = 5;
  // Issue slots per test including bubbles
  // Last test is 5 no-ops, 300 random ops and 30 bubbles
  localparam int stim_cycles  = 13 + 7 + 12 + 12 + 335;
  // Every test adds its drain and two report cycles
  localparam int total_cycles = reset_cycles + stim_cycles + num_tests * (drain_cycles + 2);
  localparam int cycle_limit  = total_cycles * 6 / 5;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_instr;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;
  logic        report_req;
  int          test_num;
  int          tests_ok;
  int          errors;
  int          cycle_count;
  integer      seed = 32'h3deb;

  mips_core u_dut (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr),
    .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
  );

  wb_checker u_checker (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr),
    .i_wb_valid(o_wb_valid), .i_wb_rd(o_wb_rd), .i_wb_data(o_wb_data),
    .i_report(report_req), .i_test_num(test_num),
    .o_tests_ok(tests_ok), .o_errors(errors)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {mips_isa_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rt, input logic [4:0] rs,
                                       input logic [15:0] imm);
    return {mips_isa_pkg::op_addi, rs, rt, imm};
  endfunction

  // Random op on r0..r7 so that dependences are frequent
  function automatic logic [31:0] rand_instr();
    logic [31:0] r;
    logic [5:0]  fn;
    r = $random(seed);
    case (r[2:0])
      3'd0:    fn = mips_isa_pkg::fn_add;
      3'd1:    fn = mips_isa_pkg::fn_sub;
      3'd2:    fn = mips_isa_pkg::fn_and;
      3'd3:    fn = mips_isa_pkg::fn_or;
      default: fn = mips_isa_pkg::fn_slt;
    endcase
    if (r[2:0] >= 3'd5) begin
      return addi({2'b00, r[5:3]}, {2'b00, r[8:6]}, r[31:16]);
    end
    return r_op(fn, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]});
  endfunction

  task automatic issue(input logic [31:0] instr);
    @(negedge i_clk);
    i_valid = 1'b1;
    i_instr = instr;
  endtask

  // Garbage on i_instr while valid is low
  task automatic bubble();
    @(negedge i_clk);
    i_valid = 1'b0;
    i_instr = $random(seed);
  endtask

  task automatic finish_test(input int num);
    repeat (drain_cycles) bubble();
    @(negedge i_clk);
    report_req = 1'b1;
    test_num   = num;
    @(negedge i_clk);
    report_req = 1'b0;
  endtask

  initial begin
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    report_req = 1'b0;
    test_num   = 0;
    repeat (reset_cycles) @(negedge i_clk);
    i_rst = 1'b0;
    // Independent ops with sources written at least four slots earlier
    issue(addi(5'd1, 5'd0, 16'd100));
    issue(addi(5'd2, 5'd0, 16'hfff9));
    issue(addi(5'd3, 5'd0, 16'h1234));
    issue(addi(5'd4, 5'd0, 16'd55));
    repeat (3) bubble();
    issue(r_op(mips_isa_pkg::fn_add, 5'd5, 5'd1, 5'd2));
    issue(r_op(mips_isa_pkg::fn_sub, 5'd6, 5'd1, 5'd3));
    issue(r_op(mips_isa_pkg::fn_and, 5'd7, 5'd3, 5'd4));
    issue(r_op(mips_isa_pkg::fn_or, 5'd8, 5'd2, 5'd4));
    issue(r_op(mips_isa_pkg::fn_slt, 5'd9, 5'd2, 5'd1));
    issue(r_op(mips_isa_pkg::fn_slt, 5'd10, 5'd1, 5'd2));
    finish_test(1);
    // Back to back producers feeding rs, rt and both
    issue(addi(5'd1, 5'd0, 16'd5));
    issue(r_op(mips_isa_pkg::fn_add, 5'd2, 5'd1, 5'd0));
    issue(r_op(mips_isa_pkg::fn_sub, 5'd3, 5'd0, 5'd2));
    issue(r_op(mips_isa_pkg::fn_add, 5'd4, 5'd3, 5'd3));
    issue(r_op(mips_isa_pkg::fn_or, 5'd5, 5'd4, 5'd4));
    issue(addi(5'd5, 5'd5, 16'hffff));
    issue(r_op(mips_isa_pkg::fn_slt, 5'd6, 5'd5, 5'd4));
    finish_test(2);
    // Distance 2 and 3 dependences with bubbles in between
    issue(addi(5'd11, 5'd0, 16'd21));
    issue(addi(5'd20, 5'd0, 16'd1));
    issue(r_op(mips_isa_pkg::fn_add, 5'd12, 5'd11, 5'd0));
    issue(addi(5'd21, 5'd0, 16'd2));
    issue(addi(5'd22, 5'd0, 16'd3));
    issue(r_op(mips_isa_pkg::fn_sub, 5'd13, 5'd0, 5'd12));
    bubble();
    issue(r_op(mips_isa_pkg::fn_and, 5'd14, 5'd13, 5'd11));
    repeat (2) bubble();
    issue(r_op(mips_isa_pkg::fn_sub, 5'd15, 5'd14, 5'd13));
    issue(r_op(mips_isa_pkg::fn_slt, 5'd16, 5'd12, 5'd15));
    finish_test(3);
    // Newer writes to r7 and r9 must win
    // Writes to r0 are reported but never read back
    issue(addi(5'd7, 5'd0, 16'd10));
    issue(addi(5'd7, 5'd0, 16'd20));
    issue(r_op(mips_isa_pkg::fn_add, 5'd8, 5'd7, 5'd0));
    issue(addi(5'd9, 5'd0, 16'd1));
    issue(addi(5'd9, 5'd0, 16'd2));
    bubble();
    issue(r_op(mips_isa_pkg::fn_add, 5'd10, 5'd9, 5'd9));
    issue(addi(5'd0, 5'd0, 16'd77));
    issue(r_op(mips_isa_pkg::fn_add, 5'd1, 5'd0, 5'd0));
    bubble();
    issue(r_op(mips_isa_pkg::fn_or, 5'd2, 5'd0, 5'd0));
    issue(addi(5'd3, 5'd0, 16'd5));
    finish_test(4);
    // lw, j, addu, sll and nor are all no-ops here
    issue(32'h8c22_0004);
    issue(32'h0800_0010);
    issue(r_op(6'h21, 5'd3, 5'd1, 5'd2));
    issue(r_op(6'h00, 5'd4, 5'd1, 5'd2));
    issue(r_op(6'h27, 5'd5, 5'd1, 5'd2));
    for (int i = 0; i < 300; i++) begin
      issue(rand_instr());
      if (i % 10 == 9) begin
        bubble();
      end
    end
    finish_test(5);
    $display("Summary: %0d of %0d tests clean, %0d errors", tests_ok, num_tests, errors);
    if (errors == 0 && tests_ok == num_tests) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Run limit with margin over the expected length
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles before all tests finished", cycle_count);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== test/wb_checker.sv ====
`timescale 1ns/1ns

module wb_checker (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_valid,
  input  logic [mips_isa_pkg::data_w-1:0]     i_instr,
  input  logic                                i_wb_valid,
  input  logic [mips_isa_pkg::reg_addr_w-1:0] i_wb_rd,
  input  logic [mips_isa_pkg::data_w-1:0]     i_wb_data,
  input  logic                                i_report,
  input  int                                  i_test_num,
  output int                                  o_tests_ok,
  output int                                  o_errors
);

  // Architectural register model, updated in program order
  logic [31:0] ref_regs [32];
  // Pending write-backs as {rd, data}, oldest first
  logic [36:0] exp_q [$];
  logic [37:0] exp_wb;
  logic [36:0] exp_head;
  int          test_checks;
  int          test_errs;
  int          missing;

  // Returns {write expected, destination, value} for one instruction
  function automatic logic [37:0] ref_wb(input logic [31:0] instr);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] y;
    logic        en;
    logic [4:0]  dst;
    a   = ref_regs[instr[25:21]];
    b   = ref_regs[instr[20:16]];
    y   = '0;
    en  = 1'b1;
    dst = instr[15:11];
    if (instr[31:26] == mips_isa_pkg::op_addi) begin
      // Destination is rt, immediate sign extended
      dst = instr[20:16];
      y   = a + {{16{instr[15]}}, instr[15:0]};
    end else if (instr[31:26] != mips_isa_pkg::op_rtype) begin
      en = 1'b0;
    end else begin
      case (instr[5:0])
        mips_isa_pkg::fn_add: y = a + b;
        mips_isa_pkg::fn_sub: y = a - b;
        mips_isa_pkg::fn_and: y = a & b;
        mips_isa_pkg::fn_or:  y = a | b;
        mips_isa_pkg::fn_slt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:              en = 1'b0;
      endcase
    end
    return {en, dst, y};
  endfunction

  // Outputs seen here are the values held over the past cycle
  always @(posedge i_clk) begin
    if (i_rst) begin
      foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
      end
      exp_q.delete();
      test_checks = 0;
      test_errs   = 0;
      o_tests_ok  = 0;
      o_errors    = 0;
    end else begin
      // Compare the retiring write-back with the oldest expectation
      if (i_wb_valid) begin
        if (exp_q.size() == 0) begin
          $display("Write-back to r%0d at %0t ns arrived with none expected", i_wb_rd, $time);
          test_errs++;
          o_errors++;
        end else begin
          exp_head = exp_q.pop_front();
          test_checks++;
          if ({i_wb_rd, i_wb_data} !== exp_head) begin
            $display("Error at %0t ns: write-back r%0d data %h, expected r%0d data %h",
                     $time, i_wb_rd, i_wb_data, exp_head[36:32], exp_head[31:0]);
            test_errs++;
            o_errors++;
          end
        end
      end
      // Accepted instruction goes through the model
      if (i_valid) begin
        exp_wb = ref_wb(i_instr);
        if (exp_wb[37]) begin
          exp_q.push_back(exp_wb[36:0]);
          // r0 is still reported but keeps its zero
          if (exp_wb[36:32] != 5'd0) begin
            ref_regs[exp_wb[36:32]] = exp_wb[31:0];
          end
        end
      end
      if (i_report) begin
        missing = exp_q.size();
        if (missing > 0) begin
          $display("Test %0d: %0d expected write-backs never arrived", i_test_num, missing);
        end
        exp_q.delete();
        test_errs = test_errs + missing;
        o_errors  = o_errors + missing;
        $display("Test %0d %s: %0d write-backs compared, %0d errors", i_test_num,
                 (test_errs == 0) ? "clean" : "with errors", test_checks, test_errs);
        if (test_errs == 0) begin
          o_tests_ok++;
        end
        test_checks = 0;
        test_errs   = 0;
      end
    end
  end

endmodule
